/* all.f */
source/cache_pkg.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache_pipe.sv
source/cache_fm_port.sv
source/cache_top.sv
tests/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cache_tb
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/cache_tb.sv */
// checks against an in-bench cache model; assumes a two-cycle response and no lookup forwarding
`timescale 1ns/1ns
module cache_tb;
  import cache_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_LOOKUPS = 2000;
  // more tags than ways so full sets must evict
  localparam int NUM_TAGS    = 6;
  localparam int WATCHDOG_NS = NUM_LOOKUPS * 20 * CLK_PERIOD;

  typedef struct packed {
    logic                valid;
    t_lu_result          res;
    t_lu_addr            addr;
    logic [CL_WIDTH-1:0] data;
    logic                push;
  } t_exp_rsp;

  typedef struct packed {
    t_fm_op                op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [CL_WIDTH-1:0]   data;
  } t_exp_fm;

  logic                  clk;
  logic                  arst_n;
  logic                  lu_valid;
  t_lu_op                lu_op;
  t_lu_addr              lu_addr;
  logic [WORD_WIDTH-1:0] lu_data;
  logic [CL_WIDTH-1:0]   lu_cl_data;
  logic                  lu_ready;
  logic                  lu_rsp_valid;
  t_lu_result            lu_rsp_result;
  logic [ADDR_WIDTH-1:0] lu_rsp_addr;
  logic [CL_WIDTH-1:0]   lu_rsp_data;
  logic                  fm_req;
  t_fm_op                fm_op;
  logic [ADDR_WIDTH-1:0] fm_addr;
  logic [CL_WIDTH-1:0]   fm_data;
  logic                  fm_ack;

  int seed;
  int n_issued;
  int n_accepted;
  int n_fm;
  int rsp_errors;
  int fm_errors;
  int ctl_errors;
  int tb_free;
  logic running;
  logic req_prev;
  logic stim_done;
  // expected contents of q2 and q3
  t_exp_rsp s1;
  t_exp_rsp s2;
  t_exp_fm  fm_q [$];

  // reference cache state
  logic [NUM_WAYS-1:0]  m_valid [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mru   [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mod   [NUM_SETS];
  logic [TAG_WIDTH-1:0] m_tag   [NUM_SETS][NUM_WAYS];
  logic [CL_WIDTH-1:0]  m_line  [NUM_SETS][NUM_WAYS];

  cache_top i_dut (
    .clk, .arst_n,
    .lu_valid, .lu_op, .lu_addr, .lu_data, .lu_cl_data, .lu_ready,
    .lu_rsp_valid, .lu_rsp_result, .lu_rsp_addr, .lu_rsp_data,
    .fm_req, .fm_op, .fm_addr, .fm_data, .fm_ack
  );

  // ====================
  // compare tasks
  // ====================
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h exp %h", name, got, exp);
      ctl_errors++;
    end
  endtask

  task automatic check_rsp(input t_lu_result got_res, input t_lu_result exp_res,
                           input logic [ADDR_WIDTH-1:0] got_addr,
                           input logic [ADDR_WIDTH-1:0] exp_addr,
                           input logic [CL_WIDTH-1:0] got_data,
                           input logic [CL_WIDTH-1:0] exp_data);
    if (got_res !== exp_res) begin
      $display("ERROR lu_rsp_result got %h exp %h", got_res, exp_res);
      rsp_errors++;
    end
    if (got_addr !== exp_addr) begin
      $display("ERROR lu_rsp_addr got %h exp %h", got_addr, exp_addr);
      rsp_errors++;
    end
    if (got_data !== exp_data) begin
      $display("ERROR lu_rsp_data got %h exp %h", got_data, exp_data);
      rsp_errors++;
    end
  endtask

  task automatic check_fm(input t_fm_op got_op, input t_fm_op exp_op,
                          input logic [ADDR_WIDTH-1:0] got_addr,
                          input logic [ADDR_WIDTH-1:0] exp_addr,
                          input logic [CL_WIDTH-1:0] got_data,
                          input logic [CL_WIDTH-1:0] exp_data);
    if (got_op !== exp_op) begin
      $display("ERROR fm_op got %h exp %h", got_op, exp_op);
      fm_errors++;
    end
    if (got_addr !== exp_addr) begin
      $display("ERROR fm_addr got %h exp %h", got_addr, exp_addr);
      fm_errors++;
    end
    if (got_data !== exp_data) begin
      $display("ERROR fm_data got %h exp %h", got_data, exp_data);
      fm_errors++;
    end
  endtask

  // ====================
  // reference model
  // ====================
  task automatic clear_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mru[s]   = '0;
      m_mod[s]   = '0;
    end
  endtask

  function automatic t_exp_rsp model_lookup(input t_lu_op op, input t_lu_addr a,
                                            input logic [WORD_WIDTH-1:0] word,
                                            input logic [CL_WIDTH-1:0] cl);
    t_exp_rsp             r;
    t_exp_fm              req;
    t_lu_addr             la;
    logic [SET_WIDTH-1:0] s;
    int                   hw;
    int                   vw;
    int                   sel;
    s  = a.f.set;
    hw = -1;
    vw = -1;
    r       = '0;
    r.valid = 1'b1;
    r.addr  = a;
    la            = a;
    la.f.offset   = '0;
    la.f.byte_idx = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[s][w] && (m_tag[s][w] == a.f.tag)) hw = w;
    end
    // first invalid way, else lowest way with mru clear
    for (int w = 0; w < NUM_WAYS; w++) begin
      if ((vw < 0) && !m_valid[s][w]) vw = w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if ((vw < 0) && !m_mru[s][w]) vw = w;
    end
    sel = (hw >= 0) ? hw : ((vw >= 0) ? vw : 0);
    if (op == FILL_LU) begin
      r.res  = FILLED;
      r.data = cl;
      // modified victim goes out under its old tag
      if ((hw < 0) && m_valid[s][sel] && m_mod[s][sel]) begin
        la.f.tag = m_tag[s][sel];
        req.op   = DIRTY_EVICT_OP;
        req.addr = la.raw;
        req.data = m_line[s][sel];
        fm_q.push_back(req);
        r.push = 1'b1;
      end
      m_valid[s][sel] = 1'b1;
      m_mod[s][sel]   = 1'b0;
      m_tag[s][sel]   = a.f.tag;
      m_line[s][sel]  = cl;
    end else if (hw >= 0) begin
      r.res = HIT;
      if (op == RD_LU) begin
        r.data = m_line[s][sel];
      end else begin
        m_line[s][sel][int'(a.f.offset) * WORD_WIDTH +: WORD_WIDTH] = word;
        m_mod[s][sel] = 1'b1;
      end
    end else begin
      r.res    = MISS;
      req.op   = FILL_REQ_OP;
      req.addr = la.raw;
      req.data = '0;
      fm_q.push_back(req);
      r.push = 1'b1;
    end
    // touched way becomes mru and a full mru set restarts from it
    if ((op == FILL_LU) || (hw >= 0)) begin
      m_mru[s][sel] = 1'b1;
      if (&m_mru[s]) begin
        m_mru[s]      = '0;
        m_mru[s][sel] = 1'b1;
      end
    end
    return r;
  endfunction

  // ====================
  // clock and watchdog
  // ====================
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout with %0d of %0d lookups accepted", n_accepted, NUM_LOOKUPS);
    $display("Test failed");
    $finish;
  end

  // far memory responder acks after 0..6 cycles and releases once req drops
  initial begin : fm_responder
    int unsigned delay;
    forever begin
      @(posedge clk);
      if (arst_n && fm_req && !fm_ack) begin
        delay = $unsigned($random(seed)) % 7;
        repeat (delay) @(posedge clk);
        fm_ack <= 1'b1;
        do @(posedge clk); while (fm_req);
        fm_ack <= 1'b0;
      end
    end
  end

  // ====================
  // monitor
  // ====================
  always @(posedge clk) begin : monitor
    t_exp_rsp nxt;
    t_exp_fm  head;
    logic     exp_ready;
    if (!arst_n) begin
      s1       = '0;
      s2       = '0;
      tb_free  = FM_QUEUE_DEPTH;
      running  = 1'b0;
      req_prev = 1'b0;
    end else begin
      // response for the lookup accepted two edges back
      check_bit("lu_rsp_valid", lu_rsp_valid, s2.valid);
      if (s2.valid && lu_rsp_valid) begin
        check_rsp(lu_rsp_result, s2.res, lu_rsp_addr, s2.addr.raw, lu_rsp_data, s2.data);
      end
      // stall on a set in q2 or q3, or on too few queue slots
      exp_ready = running
               && !(s1.valid && (s1.addr.f.set == lu_addr.f.set))
               && !(s2.valid && (s2.addr.f.set == lu_addr.f.set))
               && (tb_free >= FM_RESERVE);
      check_bit("lu_ready", lu_ready, exp_ready);
      nxt = '0;
      if (lu_valid && lu_ready) begin
        nxt = model_lookup(lu_op, lu_addr, lu_data, lu_cl_data);
        n_accepted++;
      end
      // pop edge of the four-phase handshake
      if (fm_req && fm_ack) begin
        if (fm_q.size() == 0) begin
          $display("far-memory request for %h arrived with none expected", fm_addr);
          fm_errors++;
        end else begin
          head = fm_q.pop_front();
          check_fm(fm_op, head.op, fm_addr, head.addr, fm_data, head.data);
        end
        n_fm++;
      end
      if (fm_req && !req_prev && fm_ack) begin
        $display("fm_req rose before fm_ack was released");
        ctl_errors++;
      end
      tb_free  = tb_free - int'(s2.valid && s2.push) + int'(fm_req && fm_ack);
      req_prev = fm_req;
      s2       = s1;
      s1       = nxt;
      running  = 1'b1;
    end
  end

  // ====================
  // stimulus
  // ====================
  task automatic drive_lookup();
    int unsigned pick;
    t_lu_addr    a;
    pick      = $unsigned($random(seed)) % 10;
    a.raw     = 16'($random(seed));
    a.f.tag   = 8'(($unsigned($random(seed)) % NUM_TAGS) * 8'h29);
    lu_valid <= 1'b1;
    if (pick < 4) begin
      lu_op <= RD_LU;
    end else if (pick < 7) begin
      lu_op <= WR_LU;
    end else begin
      lu_op <= FILL_LU;
    end
    lu_addr    <= a;
    lu_data    <= $random(seed);
    lu_cl_data <= {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  initial begin
    seed       = 32'h171b;
    n_issued   = 0;
    n_accepted = 0;
    n_fm       = 0;
    rsp_errors = 0;
    fm_errors  = 0;
    ctl_errors = 0;
    stim_done  = 1'b0;
    arst_n     = 1'b0;
    lu_valid   = 1'b0;
    lu_op      = RD_LU;
    lu_addr    = '0;
    lu_data    = '0;
    lu_cl_data = '0;
    fm_ack     = 1'b0;
    clear_model();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    // a pending lookup holds until accepted and about one cycle in four stays idle
    while (!stim_done) begin
      @(posedge clk);
      if (!lu_valid || lu_ready) begin
        if (n_issued == NUM_LOOKUPS) begin
          lu_valid <= 1'b0;
          stim_done = 1'b1;
        end else if (($unsigned($random(seed)) % 4) != 0) begin
          drive_lookup();
          n_issued++;
        end else begin
          lu_valid <= 1'b0;
        end
      end
    end
    // drain the pipe and the far memory queue
    while ((fm_q.size() != 0) || s1.valid || s2.valid) @(posedge clk);
    repeat (20) @(posedge clk);
    $display("lookups %0d, fm requests %0d, rsp errors %0d, fm errors %0d, ctl errors %0d",
             n_accepted, n_fm, rsp_errors, fm_errors, ctl_errors);
    if ((rsp_errors + fm_errors + ctl_errors) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* source/cache_top.sv */
// responses have no back-pressure; lu_ready must be honored and far memory must follow four-phase
`timescale 1ns/1ns
module cache_top (
  input  logic                               clk,
  input  logic                               arst_n,
  // lookup port
  input  logic                               lu_valid,
  input  cache_pkg::t_lu_op                  lu_op,
  input  cache_pkg::t_lu_addr                lu_addr,
  input  logic [cache_pkg::WORD_WIDTH-1:0]   lu_data,
  input  logic [cache_pkg::CL_WIDTH-1:0]     lu_cl_data,
  output logic                               lu_ready,
  output logic                               lu_rsp_valid,
  output cache_pkg::t_lu_result              lu_rsp_result,
  output logic [cache_pkg::ADDR_WIDTH-1:0]   lu_rsp_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]     lu_rsp_data,
  // far memory port
  output logic                               fm_req,
  output cache_pkg::t_fm_op                  fm_op,
  output logic [cache_pkg::ADDR_WIDTH-1:0]   fm_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]     fm_data,
  input  logic                               fm_ack
);
  import cache_pkg::*;

  // tag array wires
  logic                               tag_rd_en;
  logic [SET_WIDTH-1:0]               tag_rd_set;
  logic [NUM_WAYS-1:0]                tag_rd_valid;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_rd_tags;
  logic [NUM_WAYS-1:0]                tag_rd_mru;
  logic [NUM_WAYS-1:0]                tag_rd_modified;
  logic                               tag_wr_en;
  logic [SET_WIDTH-1:0]               tag_wr_set;
  logic [NUM_WAYS-1:0]                tag_wr_valid;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_wr_tags;
  logic [NUM_WAYS-1:0]                tag_wr_mru;
  logic [NUM_WAYS-1:0]                tag_wr_modified;
  // data array wires
  logic                               data_rd_en;
  logic [CL_ADDR_WIDTH-1:0]           data_rd_addr;
  logic [CL_WIDTH-1:0]                data_rd_line;
  logic                               data_wr_en;
  logic [CL_ADDR_WIDTH-1:0]           data_wr_addr;
  logic [CL_WIDTH-1:0]                data_wr_line;
  // queue wires
  logic                               fm_push;
  t_fm_op                             fm_push_op;
  logic [ADDR_WIDTH-1:0]              fm_push_addr;
  logic [CL_WIDTH-1:0]                fm_push_data;
  logic [FM_CNT_WIDTH-1:0]            fm_free;

  // ====================
  // lookup pipeline
  // ====================
  cache_pipe i_pipe (
    .clk, .arst_n,
    .lu_valid, .lu_op, .lu_addr, .lu_data, .lu_cl_data, .lu_ready,
    .lu_rsp_valid, .lu_rsp_result, .lu_rsp_addr, .lu_rsp_data,
    .tag_rd_en, .tag_rd_set, .tag_rd_valid, .tag_rd_tags, .tag_rd_mru, .tag_rd_modified,
    .tag_wr_en, .tag_wr_set, .tag_wr_valid, .tag_wr_tags, .tag_wr_mru, .tag_wr_modified,
    .data_rd_en, .data_rd_addr, .data_rd_line,
    .data_wr_en, .data_wr_addr, .data_wr_line,
    .fm_push, .fm_push_op, .fm_push_addr, .fm_push_data, .fm_free
  );

  // ====================
  // storage
  // ====================
  cache_tag_array i_tag_array (
    .clk, .arst_n,
    .rd_en       (tag_rd_en),
    .rd_set      (tag_rd_set),
    .wr_en       (tag_wr_en),
    .wr_set      (tag_wr_set),
    .wr_valid    (tag_wr_valid),
    .wr_tags     (tag_wr_tags),
    .wr_mru      (tag_wr_mru),
    .wr_modified (tag_wr_modified),
    .rd_valid    (tag_rd_valid),
    .rd_tags     (tag_rd_tags),
    .rd_mru      (tag_rd_mru),
    .rd_modified (tag_rd_modified)
  );

  cache_data_array i_data_array (
    .clk,
    .rd_en   (data_rd_en),
    .rd_addr (data_rd_addr),
    .rd_line (data_rd_line),
    .wr_en   (data_wr_en),
    .wr_addr (data_wr_addr),
    .wr_line (data_wr_line)
  );

  // far memory queue and handshake
  cache_fm_port i_fm_port (
    .clk, .arst_n,
    .push      (fm_push),
    .push_op   (fm_push_op),
    .push_addr (fm_push_addr),
    .push_data (fm_push_data),
    .free      (fm_free),
    .fm_req, .fm_op, .fm_addr, .fm_data, .fm_ack
  );

endmodule

/* source/cache_fm_port.sv */
// queue of 4; pointers rely on a power-of-two depth and the responder must follow four-phase order
`timescale 1ns/1ns
module cache_fm_port (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                push,
  input  cache_pkg::t_fm_op                   push_op,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]    push_addr,
  input  logic [cache_pkg::CL_WIDTH-1:0]      push_data,
  output logic [cache_pkg::FM_CNT_WIDTH-1:0]  free,
  output logic                                fm_req,
  output cache_pkg::t_fm_op                   fm_op,
  output logic [cache_pkg::ADDR_WIDTH-1:0]    fm_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]      fm_data,
  input  logic                                fm_ack
);
  import cache_pkg::*;

  logic [FM_PTR_WIDTH-1:0] wr_ptr;
  logic [FM_PTR_WIDTH-1:0] rd_ptr;
  t_fm_op                  q_op   [FM_QUEUE_DEPTH];
  logic [ADDR_WIDTH-1:0]   q_addr [FM_QUEUE_DEPTH];
  logic [CL_WIDTH-1:0]     q_data [FM_QUEUE_DEPTH];
  logic                    ack_wait;
  logic                    pop;
  logic                    occupied;

  // ack seen while req is up ends phase 2
  assign pop      = fm_req && fm_ack;
  assign occupied = (free != FM_CNT_WIDTH'(FM_QUEUE_DEPTH));

  // ====================
  // queue control
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      free   <= FM_CNT_WIDTH'(FM_QUEUE_DEPTH);
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   free <= free - 1'b1;
        2'b01:   free <= free + 1'b1;
        default: free <= free;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_op[wr_ptr]   <= push_op;
      q_addr[wr_ptr] <= push_addr;
      q_data[wr_ptr] <= push_data;
    end
  end

  // ====================
  // four-phase handshake
  // ====================
  // req up -> ack up -> req down, pop -> ack down -> idle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fm_req   <= 1'b0;
      ack_wait <= 1'b0;
    end else begin
      if (pop) begin
        fm_req   <= 1'b0;
        ack_wait <= 1'b1;
      end else begin
        if (!fm_ack) ack_wait <= 1'b0;
        if (!fm_req && !ack_wait && occupied && !fm_ack) fm_req <= 1'b1;
      end
    end
  end

  // head entry stays on the port until its pop
  assign fm_op   = q_op[rd_ptr];
  assign fm_addr = q_addr[rd_ptr];
  assign fm_data = q_data[rd_ptr];

  // responder only answers a raised request
  a_ack_after_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    $rose(fm_ack) |-> fm_req
  );

  // request and payload stay put until acked
  a_req_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (fm_req && !fm_ack) |=> (fm_req && $stable(fm_addr) && $stable(fm_op))
  );

endmodule

/* source/cache_pipe.sv */
// no forwarding; same-set lookups stall in q1 and each lookup pushes at most one far-memory entry
`timescale 1ns/1ns
module cache_pipe (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  // lookup request
  input  logic                                                   lu_valid,
  input  cache_pkg::t_lu_op                                      lu_op,
  input  cache_pkg::t_lu_addr                                    lu_addr,
  input  logic [cache_pkg::WORD_WIDTH-1:0]                       lu_data,
  input  logic [cache_pkg::CL_WIDTH-1:0]                         lu_cl_data,
  output logic                                                   lu_ready,
  // lookup response
  output logic                                                   lu_rsp_valid,
  output cache_pkg::t_lu_result                                  lu_rsp_result,
  output logic [cache_pkg::ADDR_WIDTH-1:0]                       lu_rsp_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]                         lu_rsp_data,
  // tag array
  output logic                                                   tag_rd_en,
  output logic [cache_pkg::SET_WIDTH-1:0]                        tag_rd_set,
  input  logic [cache_pkg::NUM_WAYS-1:0]                         tag_rd_valid,
  input  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::TAG_WIDTH-1:0] tag_rd_tags,
  input  logic [cache_pkg::NUM_WAYS-1:0]                         tag_rd_mru,
  input  logic [cache_pkg::NUM_WAYS-1:0]                         tag_rd_modified,
  output logic                                                   tag_wr_en,
  output logic [cache_pkg::SET_WIDTH-1:0]                        tag_wr_set,
  output logic [cache_pkg::NUM_WAYS-1:0]                         tag_wr_valid,
  output logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::TAG_WIDTH-1:0] tag_wr_tags,
  output logic [cache_pkg::NUM_WAYS-1:0]                         tag_wr_mru,
  output logic [cache_pkg::NUM_WAYS-1:0]                         tag_wr_modified,
  // data array
  output logic                                                   data_rd_en,
  output logic [cache_pkg::CL_ADDR_WIDTH-1:0]                    data_rd_addr,
  input  logic [cache_pkg::CL_WIDTH-1:0]                         data_rd_line,
  output logic                                                   data_wr_en,
  output logic [cache_pkg::CL_ADDR_WIDTH-1:0]                    data_wr_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]                         data_wr_line,
  // far memory queue
  output logic                                                   fm_push,
  output cache_pkg::t_fm_op                                      fm_push_op,
  output logic [cache_pkg::ADDR_WIDTH-1:0]                       fm_push_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]                         fm_push_data,
  input  logic [cache_pkg::FM_CNT_WIDTH-1:0]                     fm_free
);
  import cache_pkg::*;

  logic                 run_q;
  logic                 accept;
  // q2 stage
  logic                 q2_valid;
  t_lu_op               q2_op;
  t_lu_addr             q2_addr;
  logic [WORD_WIDTH-1:0] q2_data;
  logic [CL_WIDTH-1:0]  q2_cl_data;
  logic [NUM_WAYS-1:0]  hit_vec;
  logic                 hit;
  logic [WAY_WIDTH-1:0] hit_way;
  logic [WAY_WIDTH-1:0] victim_way;
  logic [WAY_WIDTH-1:0] sel_way;
  logic [NUM_WAYS-1:0]  touch_vec;
  logic                 q2_evict;
  // q3 stage
  logic                 q3_valid;
  t_lu_op               q3_op;
  t_lu_addr             q3_addr;
  logic [WORD_WIDTH-1:0] q3_data;
  logic [CL_WIDTH-1:0]  q3_cl_data;
  logic                 q3_hit;
  logic [WAY_WIDTH-1:0] q3_way;
  logic                 q3_evict;
  logic [TAG_WIDTH-1:0] q3_evict_tag;
  logic [CL_WIDTH-1:0]  merged_line;
  t_lu_addr             line_addr;
  t_lu_addr             evict_addr;

  // ====================
  // q1
  // ====================
  // goes high on the first edge after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // stall on a set still in q2 or q3, or when the queue cannot absorb three pushes
  assign lu_ready = run_q
                 && !(q2_valid && (q2_addr.f.set == lu_addr.f.set))
                 && !(q3_valid && (q3_addr.f.set == lu_addr.f.set))
                 && (fm_free >= FM_CNT_WIDTH'(FM_RESERVE));
  assign accept     = lu_valid && lu_ready;
  assign tag_rd_en  = accept;
  assign tag_rd_set = lu_addr.f.set;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q2_valid <= 1'b0;
      q3_valid <= 1'b0;
    end else begin
      q2_valid <= accept;
      q3_valid <= q2_valid;
    end
  end

  // q1 payload into q2
  always_ff @(posedge clk) begin
    q2_op      <= lu_op;
    q2_addr    <= lu_addr;
    q2_data    <= lu_data;
    q2_cl_data <= lu_cl_data;
  end

  // ====================
  // q2
  // ====================
  // tag compare and way select
  always_comb begin
    hit_way    = '0;
    victim_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = q2_valid && tag_rd_valid[w] && (tag_rd_tags[w] == q2_addr.f.tag);
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) hit_way = WAY_WIDTH'(w);
    end
    // lowest way with mru clear
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!tag_rd_mru[w]) victim_way = WAY_WIDTH'(w);
    end
    // an invalid way wins over the mru choice
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!tag_rd_valid[w]) victim_way = WAY_WIDTH'(w);
    end
  end

  assign hit = |hit_vec;
  // fill to a resident line reuses its way
  assign sel_way = hit ? hit_way : victim_way;

  // only a fill that displaces a modified line evicts
  assign q2_evict = q2_valid && (q2_op == FILL_LU) && !hit
                 && tag_rd_valid[sel_way] && tag_rd_modified[sel_way];

  // set update; misses leave the set untouched
  always_comb begin
    touch_vec          = '0;
    touch_vec[sel_way] = 1'b1;
    tag_wr_en          = q2_valid && ((q2_op == FILL_LU) || hit);
    tag_wr_set         = q2_addr.f.set;
    tag_wr_valid       = tag_rd_valid;
    tag_wr_tags        = tag_rd_tags;
    tag_wr_modified    = tag_rd_modified;
    tag_wr_mru         = tag_rd_mru | touch_vec;
    // an all-set mru vector restarts from the touched way
    if (&tag_wr_mru) tag_wr_mru = touch_vec;
    if ((q2_op == WR_LU) && hit) tag_wr_modified = tag_rd_modified | touch_vec;
    if (q2_op == FILL_LU) begin
      tag_wr_valid         = tag_rd_valid | touch_vec;
      tag_wr_tags[sel_way] = q2_addr.f.tag;
      tag_wr_modified      = tag_rd_modified & ~touch_vec;
    end
  end

  // fetch hit line or victim's old line
  assign data_rd_en   = q2_valid;
  assign data_rd_addr = {q2_addr.f.set, sel_way};

  always_ff @(posedge clk) begin
    q3_op        <= q2_op;
    q3_addr      <= q2_addr;
    q3_data      <= q2_data;
    q3_cl_data   <= q2_cl_data;
    q3_hit       <= hit;
    q3_way       <= sel_way;
    q3_evict     <= q2_evict;
    q3_evict_tag <= tag_rd_tags[sel_way];
  end

  // ====================
  // q3
  // ====================
  // response
  assign lu_rsp_valid  = q3_valid;
  assign lu_rsp_result = !q3_valid          ? NO_RSP :
                         (q3_op == FILL_LU) ? FILLED :
                         q3_hit             ? HIT    : MISS;
  assign lu_rsp_addr   = q3_addr.raw;
  assign lu_rsp_data   = (q3_op == FILL_LU)          ? q3_cl_data   :
                         ((q3_op == RD_LU) && q3_hit) ? data_rd_line : '0;

  // one word replaced at its offset
  always_comb begin
    for (int w = 0; w < NUM_WORDS_IN_CL; w++) begin
      if (OFFSET_WIDTH'(w) == q3_addr.f.offset) begin
        merged_line[w*WORD_WIDTH +: WORD_WIDTH] = q3_data;
      end else begin
        merged_line[w*WORD_WIDTH +: WORD_WIDTH] = data_rd_line[w*WORD_WIDTH +: WORD_WIDTH];
      end
    end
  end

  assign data_wr_en   = q3_valid && ((q3_op == FILL_LU) || ((q3_op == WR_LU) && q3_hit));
  assign data_wr_addr = {q3_addr.f.set, q3_way};
  assign data_wr_line = (q3_op == FILL_LU) ? q3_cl_data : merged_line;

  // line address and the evict address rebuilt from the old tag
  always_comb begin
    line_addr            = q3_addr;
    line_addr.f.offset   = '0;
    line_addr.f.byte_idx = '0;
    evict_addr           = line_addr;
    evict_addr.f.tag     = q3_evict_tag;
  end

  // a read or write miss asks for the line and a dirty fill victim goes out
  assign fm_push      = q3_valid && (((q3_op != FILL_LU) && !q3_hit) || q3_evict);
  assign fm_push_op   = q3_evict ? DIRTY_EVICT_OP : FILL_REQ_OP;
  assign fm_push_addr = q3_evict ? evict_addr.raw : line_addr.raw;
  assign fm_push_data = q3_evict ? data_rd_line : '0;

  // a tag is resident in one way at most
  a_hit_onehot: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(hit_vec)
  );

  // the lu_ready reservation keeps the queue from overflowing
  a_push_has_room: assert property (
    @(posedge clk) disable iff (!arst_n)
    fm_push |-> (fm_free != '0)
  );

endmodule

/* source/cache_data_array.sv */
// 64 lines with no reset; contents are undefined until filled and reads are registered
`timescale 1ns/1ns
module cache_data_array (
  input  logic                               clk,
  input  logic                               rd_en,
  input  logic [cache_pkg::CL_ADDR_WIDTH-1:0] rd_addr,
  output logic [cache_pkg::CL_WIDTH-1:0]      rd_line,
  input  logic                               wr_en,
  input  logic [cache_pkg::CL_ADDR_WIDTH-1:0] wr_addr,
  input  logic [cache_pkg::CL_WIDTH-1:0]      wr_line
);
  import cache_pkg::*;

  // one entry per {set, way}
  logic [CL_WIDTH-1:0] mem [NUM_SETS * NUM_WAYS];

  // full-line write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_line;
    end
  end

  // read data lands one cycle later, in q3
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_line <= mem[rd_addr];
    end
  end

endmodule

/* source/cache_tag_array.sv */
// reads return one cycle later; a write to the set being read in the same cycle is not forwarded
`timescale 1ns/1ns
module cache_tag_array (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  input  logic                                                   rd_en,
  input  logic [cache_pkg::SET_WIDTH-1:0]                        rd_set,
  input  logic                                                   wr_en,
  input  logic [cache_pkg::SET_WIDTH-1:0]                        wr_set,
  input  logic [cache_pkg::NUM_WAYS-1:0]                         wr_valid,
  input  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::TAG_WIDTH-1:0] wr_tags,
  input  logic [cache_pkg::NUM_WAYS-1:0]                         wr_mru,
  input  logic [cache_pkg::NUM_WAYS-1:0]                         wr_modified,
  output logic [cache_pkg::NUM_WAYS-1:0]                         rd_valid,
  output logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::TAG_WIDTH-1:0] rd_tags,
  output logic [cache_pkg::NUM_WAYS-1:0]                         rd_mru,
  output logic [cache_pkg::NUM_WAYS-1:0]                         rd_modified
);
  import cache_pkg::*;

  // per-set state bits
  logic [NUM_WAYS-1:0]                valid_q    [NUM_SETS];
  logic [NUM_WAYS-1:0]                mru_q      [NUM_SETS];
  logic [NUM_WAYS-1:0]                modified_q [NUM_SETS];
  // tag per way and set
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags_q     [NUM_SETS];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s]    <= '0;
        mru_q[s]      <= '0;
        modified_q[s] <= '0;
      end
    end else if (wr_en) begin
      valid_q[wr_set]    <= wr_valid;
      mru_q[wr_set]      <= wr_mru;
      modified_q[wr_set] <= wr_modified;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags_q[wr_set] <= wr_tags;
    end
  end

  // ====================
  // registered read
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid    <= '0;
      rd_mru      <= '0;
      rd_modified <= '0;
    end else if (rd_en) begin
      rd_valid    <= valid_q[rd_set];
      rd_mru      <= mru_q[rd_set];
      rd_modified <= modified_q[rd_set];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tags <= tags_q[rd_set];
    end
  end

  // pipe hazard rule keeps a set update away from a set still being read
  a_no_rd_wr_same_set: assert property (
    @(posedge clk) disable iff (!arst_n)
    (rd_en && wr_en) |-> (rd_set != wr_set)
  );

endmodule

/* source/cache_pkg.sv */
// geometry is fixed at 4 ways x 16 sets x 4 words; pointer and count widths assume these values
package cache_pkg;

  // ====================
  // geometry
  // ====================
  localparam int ADDR_WIDTH      = 16;
  localparam int WORD_WIDTH      = 32;
  localparam int NUM_WORDS_IN_CL = 4;
  localparam int NUM_WAYS        = 4;
  localparam int WAY_WIDTH       = 2;
  localparam int NUM_SETS        = 16;
  localparam int SET_WIDTH       = 4;
  localparam int OFFSET_WIDTH    = 2;
  localparam int BYTE_WIDTH      = 2;
  localparam int TAG_WIDTH       = 8;
  localparam int CL_WIDTH        = NUM_WORDS_IN_CL * WORD_WIDTH;
  // data array index is {set, way}
  localparam int CL_ADDR_WIDTH   = SET_WIDTH + WAY_WIDTH;

  // ====================
  // far memory queue
  // ====================
  localparam int FM_QUEUE_DEPTH  = 4;
  localparam int FM_PTR_WIDTH    = 2;
  // free count runs 0..FM_QUEUE_DEPTH
  localparam int FM_CNT_WIDTH    = 3;
  // one slot each for q2, q3 and the lookup being accepted
  localparam int FM_RESERVE      = 3;

  // ====================
  // opcodes and results
  // ====================
  typedef enum logic [1:0] {
    RD_LU,
    WR_LU,
    FILL_LU
  } t_lu_op;

  typedef enum logic [1:0] {
    NO_RSP,
    HIT,
    MISS,
    FILLED
  } t_lu_result;

  typedef enum logic {
    FILL_REQ_OP,
    DIRTY_EVICT_OP
  } t_fm_op;

  // address fields from the msb down
  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [SET_WIDTH-1:0]    set;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [BYTE_WIDTH-1:0]   byte_idx;
  } t_lu_addr_fields;

  // same word seen raw or split
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    t_lu_addr_fields       f;
  } t_lu_addr;

endpackage
